/* verilog/thumb_ctrl_pkg.sv */
`default_nettype none

package thumb_ctrl_pkg;

    // instruction classes kept by this controller
    typedef enum logic [2:0] {
        CLS_SHIFT_IMM,
        CLS_DATA_PROC,
        CLS_LS_REG,
        CLS_LS_IMM,
        CLS_STM,
        CLS_LDM,
        CLS_UNKNOWN
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_BIT_CLEAR,
        ALU_NOT,
        ALU_MULT,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR,
        ALU_ADC,
        ALU_SBC,
        ALU_ROR
    } alu_op_e;

    // SRC_OFFSET selects the byte offset of the current multi-register beat
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_ZERO,
        SRC_OFFSET
    } alu_src_e;

    typedef struct packed {
        logic     valid;
        logic     multi;
        logic     update_flag;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     wb_from_mem;
        alu_src_e src1;
        alu_src_e src2;
        alu_op_e  alu_op;
        // store data is read through the third register field
        logic     reg2_is_reg3;
    } ctrl_t;

endpackage

`default_nettype wire

/* verilog/thumb_regs_pkg.sv */
`default_nettype none

package thumb_regs_pkg;

    typedef logic [3:0] reg_addr_t;

    // one bit per low register r0 to r7
    typedef logic [7:0] lo_list_t;

    typedef struct packed {
        logic        stall;
        reg_addr_t   reg_addr;
        // destination register number comes from reg_addr instead of the instruction
        logic        dest_from_ctrl;
        // second read port address comes from reg_addr instead of the instruction
        logic        addr2_from_ctrl;
        logic [31:0] offset;
        logic        mem_write;
        logic        mem_read;
        logic        reg_write;
        logic        wb_from_mem;
    } xfer_t;

endpackage

`default_nettype wire

/* verilog/inst_decoder.sv */
`default_nettype none

module inst_decoder import thumb_ctrl_pkg::*, thumb_regs_pkg::*; (
    input  wire logic [15:0] instruction_i,
    input  wire logic        is_valid_i,
    output ctrl_t            ctrl_o,
    output logic             multi_req_o,
    output logic             multi_load_o,
    output reg_addr_t        base_reg_o,
    output lo_list_t         reg_list_o
);

    typedef enum logic [3:0] {
        DP_AND, DP_EOR, DP_LSL, DP_LSR, DP_ASR, DP_ADC, DP_SBC, DP_ROR,
        DP_TST, DP_RSB, DP_CMP, DP_CMN, DP_ORR, DP_MUL, DP_BIC, DP_MVN
    } dp_op_e;

    op_class_e op_class;
    dp_op_e    dp_op;
    logic      is_load;

    always_comb begin
        casez (instruction_i[15:11])
            5'b000??, 5'b001??: op_class = CLS_SHIFT_IMM;
            // 010001 is the special-data group, which is not supported
            5'b01000: op_class = instruction_i[10] ? CLS_UNKNOWN : CLS_DATA_PROC;
            5'b0101?: op_class = CLS_LS_REG;
            5'b011??, 5'b1000?: op_class = CLS_LS_IMM;
            5'b11000: op_class = CLS_STM;
            5'b11001: op_class = CLS_LDM;
            default: op_class = CLS_UNKNOWN;
        endcase
    end

    assign dp_op = dp_op_e'(instruction_i[9:6]);

    // register-offset group has the signed loads at 011 alongside the load bit
    assign is_load = instruction_i[11] ||
                     (op_class == CLS_LS_REG && instruction_i[10:9] == 2'b11);

    always_comb begin
        ctrl_o = '0;
        ctrl_o.valid = 1'b1;
        ctrl_o.src1 = SRC_REG;
        ctrl_o.src2 = SRC_REG;
        ctrl_o.alu_op = ALU_ADD;

        case (op_class)
            CLS_SHIFT_IMM: begin
                ctrl_o.update_flag = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.src2 = SRC_IMM;
                casez (instruction_i[13:9])
                    5'b000??: ctrl_o.alu_op = ALU_LSL;
                    5'b001??: ctrl_o.alu_op = ALU_LSR;
                    5'b010??: ctrl_o.alu_op = ALU_ASR;
                    5'b01100: ctrl_o.src2 = SRC_REG;
                    5'b01101: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.src2 = SRC_REG;
                    end
                    5'b01111, 5'b111??: ctrl_o.alu_op = ALU_SUB;
                    // mov is computed as zero plus the immediate
                    5'b100??: ctrl_o.src1 = SRC_ZERO;
                    5'b101??: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.reg_write = 1'b0;
                    end
                    default: ;
                endcase
            end
            CLS_DATA_PROC: begin
                ctrl_o.update_flag = 1'b1;
                ctrl_o.reg_write = 1'b1;
                case (dp_op)
                    DP_AND: ctrl_o.alu_op = ALU_AND;
                    DP_EOR: ctrl_o.alu_op = ALU_XOR;
                    DP_LSL: ctrl_o.alu_op = ALU_LSL;
                    DP_LSR: ctrl_o.alu_op = ALU_LSR;
                    DP_ASR: ctrl_o.alu_op = ALU_ASR;
                    DP_ADC: ctrl_o.alu_op = ALU_ADC;
                    DP_SBC: ctrl_o.alu_op = ALU_SBC;
                    DP_ROR: ctrl_o.alu_op = ALU_ROR;
                    DP_TST: begin
                        ctrl_o.alu_op = ALU_AND;
                        ctrl_o.reg_write = 1'b0;
                    end
                    DP_RSB: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.src1 = SRC_ZERO;
                    end
                    DP_CMP: begin
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.reg_write = 1'b0;
                    end
                    DP_CMN: ctrl_o.reg_write = 1'b0;
                    DP_ORR: ctrl_o.alu_op = ALU_OR;
                    DP_MUL: ctrl_o.alu_op = ALU_MULT;
                    DP_BIC: ctrl_o.alu_op = ALU_BIT_CLEAR;
                    DP_MVN: ctrl_o.alu_op = ALU_NOT;
                    default: ;
                endcase
            end
            CLS_LS_REG, CLS_LS_IMM: begin
                if (op_class == CLS_LS_IMM) begin
                    ctrl_o.src2 = SRC_IMM;
                end
                if (is_load) begin
                    ctrl_o.mem_read = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                    ctrl_o.wb_from_mem = 1'b1;
                end else begin
                    ctrl_o.mem_write = 1'b1;
                    ctrl_o.reg2_is_reg3 = (op_class == CLS_LS_REG);
                end
            end
            // the burst enables travel on the transfer controls
            CLS_STM, CLS_LDM: begin
                ctrl_o.multi = 1'b1;
                ctrl_o.src2 = SRC_OFFSET;
            end
            default: ctrl_o.valid = 1'b0;
        endcase

        // an empty slot must not enable anything downstream
        if (!is_valid_i) begin
            ctrl_o.valid = 1'b0;
            ctrl_o.multi = 1'b0;
            ctrl_o.update_flag = 1'b0;
            ctrl_o.mem_read = 1'b0;
            ctrl_o.mem_write = 1'b0;
            ctrl_o.reg_write = 1'b0;
        end
    end

    assign multi_req_o = is_valid_i && (op_class == CLS_STM || op_class == CLS_LDM);
    assign multi_load_o = (op_class == CLS_LDM);
    assign base_reg_o = {1'b0, instruction_i[10:8]};
    assign reg_list_o = instruction_i[7:0];

endmodule

`default_nettype wire

/* verilog/reg_list_picker.sv */
`default_nettype none

module reg_list_picker import thumb_regs_pkg::*; (
    input  lo_list_t         list_i,
    input  lo_list_t         remaining_i,
    input  wire logic        reverse_i,
    output logic             any_left_o,
    output reg_addr_t        pick_addr_o,
    output lo_list_t         pick_onehot_o,
    output logic [3:0]       list_count_o
);

    lo_list_t pending;

    assign pending = list_i & remaining_i;
    assign any_left_o = |pending;

    // forward order takes the lowest pending register, reverse the highest
    always_comb begin : pick
        logic       found;
        logic [2:0] idx;
        found = 1'b0;
        pick_addr_o = '0;
        for (int i = 0; i < 8; i++) begin
            idx = reverse_i ? 3'(7 - i) : 3'(i);
            if (pending[idx] && !found) begin
                pick_addr_o = {1'b0, idx};
                found = 1'b1;
            end
        end
    end

    assign pick_onehot_o = any_left_o ? lo_list_t'(8'b1 << pick_addr_o[2:0]) : '0;

    always_comb begin
        list_count_o = '0;
        for (int i = 0; i < 8; i++) begin
            list_count_o = list_count_o + 4'(list_i[i]);
        end
    end

    // the picked bit must be one the counter still has pending
    pick_is_pending_a: assert final (
        $onehot0(pick_onehot_o) && ((pick_onehot_o & ~pending) == '0)
    );

endmodule

`default_nettype wire

/* verilog/transfer_counter.sv */
`default_nettype none

module transfer_counter import thumb_regs_pkg::*; #(
    parameter int unsigned XFER_STEP = 4
) (
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire logic        burst_active_i,
    input  wire logic        advance_i,
    input  lo_list_t         pick_onehot_i,
    input  wire logic [3:0]  list_count_i,
    output lo_list_t         remaining_o,
    output logic [31:0]      beat_offset_o,
    output logic [31:0]      reverse_offset_o,
    output logic [31:0]      writeback_offset_o
);

    logic [3:0] beat_count;
    lo_list_t   remaining_q;

    // an idle or finished burst leaves the counter ready for the next one
    always_ff @(posedge clk_i) begin
        if (reset_i || !burst_active_i) begin
            beat_count <= '0;
            remaining_q <= '1;
        end else if (advance_i) begin
            beat_count <= beat_count + 4'd1;
            remaining_q <= remaining_q & ~pick_onehot_i;
        end
    end

    assign remaining_o = remaining_q;

    assign beat_offset_o = 32'(beat_count * XFER_STEP);
    assign writeback_offset_o = 32'(list_count_i * XFER_STEP);

    // descending transfers fill the block from its top word downwards
    assign reverse_offset_o = writeback_offset_o - beat_offset_o - 32'(XFER_STEP);

endmodule

`default_nettype wire

/* verilog/multi_xfer_fsm.sv */
`default_nettype none

module multi_xfer_fsm import thumb_regs_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire logic        multi_req_i,
    input  wire logic        multi_load_i,
    input  reg_addr_t        base_reg_i,
    input  lo_list_t         reg_list_i,
    input  wire logic        any_left_i,
    input  reg_addr_t        pick_addr_i,
    input  wire logic [3:0]  list_count_i,
    input  wire logic [31:0] beat_offset_i,
    input  wire logic [31:0] reverse_offset_i,
    input  wire logic [31:0] writeback_offset_i,
    output logic             burst_active_o,
    output logic             advance_o,
    output logic             reverse_o,
    output xfer_t            xfer_o
);

    typedef enum logic {
        IDLE,
        BURST
    } state_e;

    state_e state_q;
    logic   has_work;
    logic   beat;
    logic   base_in_list;

    // in IDLE the mask is full, so a nonzero count means registers are left
    assign has_work = (state_q == IDLE) ? (list_count_i != 4'd0) : any_left_i;
    assign beat = multi_req_i && has_work;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (beat) state_q <= BURST;
                BURST: if (!beat) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // dropping out of BURST without a beat is the write-back or an abort
    assign burst_active_o = multi_req_i && (has_work || state_q == IDLE);
    assign advance_o = beat;
    assign reverse_o = multi_load_i;

    assign base_in_list = !base_reg_i[3] && reg_list_i[base_reg_i[2:0]];

    always_comb begin
        xfer_o = '0;
        if (beat) begin
            xfer_o.stall = 1'b1;
            xfer_o.reg_addr = pick_addr_i;
            if (multi_load_i) begin
                xfer_o.mem_read = 1'b1;
                xfer_o.reg_write = 1'b1;
                xfer_o.wb_from_mem = 1'b1;
                xfer_o.dest_from_ctrl = 1'b1;
                xfer_o.offset = reverse_offset_i;
            end else begin
                xfer_o.mem_write = 1'b1;
                xfer_o.addr2_from_ctrl = 1'b1;
                xfer_o.offset = beat_offset_i;
            end
        end else if (multi_req_i) begin
            // base write-back, which a load of the base itself overrides
            xfer_o.reg_addr = base_reg_i;
            xfer_o.dest_from_ctrl = 1'b1;
            xfer_o.offset = writeback_offset_i;
            xfer_o.reg_write = !(multi_load_i && base_in_list);
        end
    end

    mem_dir_a: assert property (@(posedge clk_i) disable iff (reset_i)
        !(xfer_o.mem_read && xfer_o.mem_write));

    // at most eight low registers, so a burst never holds the pipeline longer
    stall_limit_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == IDLE && xfer_o.stall) |-> ##[1:8] !xfer_o.stall);

    idle_counter_clear_a: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == IDLE) |-> (beat_offset_i == '0));

endmodule

`default_nettype wire

/* verilog/thumb_ctrl.sv */
`default_nettype none

module thumb_ctrl import thumb_ctrl_pkg::*, thumb_regs_pkg::*; #(
    parameter int unsigned XFER_STEP = 4
) (
    input  wire logic        clk_i,
    input  wire logic        reset_i,
    input  wire logic        is_valid_i,
    input  wire logic [15:0] instruction_i,
    output ctrl_t            ctrl_o,
    output xfer_t            xfer_o
);

    logic        multi_req;
    logic        multi_load;
    reg_addr_t   base_reg;
    lo_list_t    reg_list;
    lo_list_t    remaining;
    lo_list_t    pick_onehot;
    reg_addr_t   pick_addr;
    logic        any_left;
    logic        reverse;
    logic        burst_active;
    logic        advance;
    logic [3:0]  list_count;
    logic [31:0] beat_offset;
    logic [31:0] reverse_offset;
    logic [31:0] writeback_offset;

    inst_decoder inst_decoder_i (
        .instruction_i (instruction_i),
        .is_valid_i    (is_valid_i),
        .ctrl_o        (ctrl_o),
        .multi_req_o   (multi_req),
        .multi_load_o  (multi_load),
        .base_reg_o    (base_reg),
        .reg_list_o    (reg_list)
    );

    reg_list_picker reg_list_picker_i (
        .list_i        (reg_list),
        .remaining_i   (remaining),
        .reverse_i     (reverse),
        .any_left_o    (any_left),
        .pick_addr_o   (pick_addr),
        .pick_onehot_o (pick_onehot),
        .list_count_o  (list_count)
    );

    transfer_counter #(
        .XFER_STEP (XFER_STEP)
    ) transfer_counter_i (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .burst_active_i     (burst_active),
        .advance_i          (advance),
        .pick_onehot_i      (pick_onehot),
        .list_count_i       (list_count),
        .remaining_o        (remaining),
        .beat_offset_o      (beat_offset),
        .reverse_offset_o   (reverse_offset),
        .writeback_offset_o (writeback_offset)
    );

    multi_xfer_fsm multi_xfer_fsm_i (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .multi_req_i        (multi_req),
        .multi_load_i       (multi_load),
        .base_reg_i         (base_reg),
        .reg_list_i         (reg_list),
        .any_left_i         (any_left),
        .pick_addr_i        (pick_addr),
        .list_count_i       (list_count),
        .beat_offset_i      (beat_offset),
        .reverse_offset_i   (reverse_offset),
        .writeback_offset_i (writeback_offset),
        .burst_active_o     (burst_active),
        .advance_o          (advance),
        .reverse_o          (reverse),
        .xfer_o             (xfer_o)
    );

endmodule

`default_nettype wire

/* verif/thumb_ctrl_tb.sv */
`default_nettype none

module thumb_ctrl_tb import thumb_ctrl_pkg::*, thumb_regs_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int STEP = 4;
    // eight beats at most, then the write-back and a spare cycle
    localparam int MAX_CYCLES_PER_TEST = 11;
    localparam int ABORT_BEATS = 2;
    localparam logic [1:0] K_SINGLE = 2'd0;
    localparam logic [1:0] K_BURST = 2'd1;
    localparam logic [1:0] K_ABORT = 2'd2;

    typedef struct packed {
        logic [15:0]     instr;
        logic [1:0]      kind;
        ctrl_t           ctrl;
        logic [3:0]      beats;
        logic [7:0][3:0] addrs;
        logic [7:0][7:0] offs;
        logic [7:0]      wb_off;
        logic            wb_write;
    } test_t;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        is_valid;
    logic [15:0] instruction;
    ctrl_t       ctrl;
    xfer_t       xfer;

    test_t       tests_q[$];
    logic [31:0] lfsr_q = 32'hfa16_88e1;
    int          err_count = 0;
    int          failed_tests = 0;
    int          watchdog_ns = 0;

    thumb_ctrl #(
        .XFER_STEP (STEP)
    ) thumb_ctrl_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .is_valid_i    (is_valid),
        .instruction_i (instruction),
        .ctrl_o        (ctrl),
        .xfer_o        (xfer)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    function automatic ctrl_t alu_ctrl(input logic rw, input alu_src_e s1, input alu_src_e s2,
                                       input alu_op_e op);
        ctrl_t c;
        c = '0;
        c.valid = 1'b1;
        c.update_flag = 1'b1;
        c.reg_write = rw;
        c.src1 = s1;
        c.src2 = s2;
        c.alu_op = op;
        return c;
    endfunction

    function automatic ctrl_t mem_ctrl(input logic load, input alu_src_e s2, input logic r23);
        ctrl_t c;
        c = '0;
        c.valid = 1'b1;
        c.src2 = s2;
        c.mem_read = load;
        c.reg_write = load;
        c.wb_from_mem = load;
        c.mem_write = !load;
        c.reg2_is_reg3 = r23;
        return c;
    endfunction

    task automatic add_single(input logic [15:0] instr, input ctrl_t c);
        test_t t;
        t = '0;
        t.instr = instr;
        t.kind = K_SINGLE;
        t.ctrl = c;
        tests_q.push_back(t);
    endtask

    task automatic add_burst(input logic [1:0] kind, input logic load, input logic [2:0] base,
                             input logic [7:0] list);
        test_t t;
        int    n;
        int    k;
        t = '0;
        n = 0;
        k = 0;
        for (int i = 0; i < 8; i++) begin
            if (list[i]) n++;
        end
        t.instr = {4'b1100, load, base, list};
        t.kind = kind;
        t.ctrl.valid = 1'b1;
        t.ctrl.multi = 1'b1;
        t.ctrl.src2 = SRC_OFFSET;
        t.beats = 4'(n);
        // STM walks up through the list from offset zero, LDM walks down from the top word
        for (int i = 0; i < 8; i++) begin
            if (load ? list[7 - i] : list[i]) begin
                t.addrs[k] = load ? 4'(7 - i) : 4'(i);
                t.offs[k] = load ? 8'((n - 1 - k) * STEP) : 8'(k * STEP);
                k++;
            end
        end
        t.wb_off = 8'(n * STEP);
        t.wb_write = !(load && list[base]);
        tests_q.push_back(t);
    endtask

    task automatic build_tests;
        logic [7:0] base;
        logic [7:0] list;
        add_single(16'h0048, alu_ctrl(1'b1, SRC_REG, SRC_IMM, ALU_LSL));
        add_single(16'h0848, alu_ctrl(1'b1, SRC_REG, SRC_IMM, ALU_LSR));
        add_single(16'h1048, alu_ctrl(1'b1, SRC_REG, SRC_IMM, ALU_ASR));
        add_single(16'h1848, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_ADD));
        add_single(16'h1A48, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_SUB));
        add_single(16'h1C48, alu_ctrl(1'b1, SRC_REG, SRC_IMM, ALU_ADD));
        add_single(16'h1E48, alu_ctrl(1'b1, SRC_REG, SRC_IMM, ALU_SUB));
        add_single(16'h2155, alu_ctrl(1'b1, SRC_ZERO, SRC_IMM, ALU_ADD));
        add_single(16'h2955, alu_ctrl(1'b0, SRC_REG, SRC_IMM, ALU_SUB));
        add_single(16'h3155, alu_ctrl(1'b1, SRC_REG, SRC_IMM, ALU_ADD));
        add_single(16'h3955, alu_ctrl(1'b1, SRC_REG, SRC_IMM, ALU_SUB));
        add_single(16'h4011, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_AND));
        add_single(16'h4051, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_XOR));
        add_single(16'h4091, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_LSL));
        add_single(16'h40D1, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_LSR));
        add_single(16'h4111, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_ASR));
        add_single(16'h4151, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_ADC));
        add_single(16'h4191, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_SBC));
        add_single(16'h41D1, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_ROR));
        add_single(16'h4211, alu_ctrl(1'b0, SRC_REG, SRC_REG, ALU_AND));
        add_single(16'h4251, alu_ctrl(1'b1, SRC_ZERO, SRC_REG, ALU_SUB));
        add_single(16'h4291, alu_ctrl(1'b0, SRC_REG, SRC_REG, ALU_SUB));
        add_single(16'h42D1, alu_ctrl(1'b0, SRC_REG, SRC_REG, ALU_ADD));
        add_single(16'h4311, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_OR));
        add_single(16'h4351, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_MULT));
        add_single(16'h4391, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_BIT_CLEAR));
        add_single(16'h43D1, alu_ctrl(1'b1, SRC_REG, SRC_REG, ALU_NOT));
        // special-data and branch encodings are outside the kept classes
        add_single(16'h4411, '0);
        add_single(16'hE000, '0);
        add_single(16'h5088, mem_ctrl(1'b0, SRC_REG, 1'b1));
        add_single(16'h5888, mem_ctrl(1'b1, SRC_REG, 1'b0));
        add_single(16'h5688, mem_ctrl(1'b1, SRC_REG, 1'b0));
        add_single(16'h6088, mem_ctrl(1'b0, SRC_IMM, 1'b0));
        add_single(16'h6888, mem_ctrl(1'b1, SRC_IMM, 1'b0));
        add_single(16'h8088, mem_ctrl(1'b0, SRC_IMM, 1'b0));
        add_single(16'h8888, mem_ctrl(1'b1, SRC_IMM, 1'b0));
        add_burst(K_BURST, 1'b0, 3'd3, 8'h00);
        add_burst(K_BURST, 1'b1, 3'd2, 8'hFF);
        add_burst(K_BURST, 1'b1, 3'd5, 8'h03);
        for (int i = 0; i < 4; i++) begin
            take_bits(3, base);
            take_bits(8, list);
            add_burst(K_BURST, 1'b0, base[2:0], list);
        end
        for (int i = 0; i < 4; i++) begin
            take_bits(3, base);
            take_bits(8, list);
            add_burst(K_BURST, 1'b1, base[2:0], list);
        end
        // the same STM follows the aborted one and must start again at r1
        add_burst(K_ABORT, 1'b0, 3'd1, 8'hB6);
        add_burst(K_BURST, 1'b0, 3'd1, 8'hB6);
    endtask

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            K_SINGLE: return "single";
            K_BURST: return "burst";
            default: return "abort";
        endcase
    endfunction

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d mismatches", name, err_count - errs_before);
        end
    endtask

    task automatic run_test(input int idx);
        test_t t;
        int    errs_before;
        int    beat;
        logic  load;
        logic  done;
        logic  aborted;
        t = tests_q[idx];
        errs_before = err_count;
        beat = 0;
        load = t.instr[11];
        done = 1'b0;
        aborted = 1'b0;
        instruction = t.instr;
        is_valid = 1'b1;
        #1;
        check(ctrl, t.ctrl, "decoded control");
        if (t.kind == K_SINGLE) begin
            check(xfer, '0, "transfer controls of a single-cycle instruction");
        end else begin
            while (!done) begin
                if (!xfer.stall) begin
                    done = 1'b1;
                end else if (beat == 8) begin
                    $display("ERROR %0t: stall stayed high for more than 8 cycles", $time);
                    err_count++;
                    done = 1'b1;
                end else begin
                    check(xfer.reg_addr, t.addrs[beat], "beat register");
                    check(xfer.offset, t.offs[beat], "beat offset");
                    // loads write the register file from memory, stores read the store data
                    check({xfer.mem_read, xfer.mem_write, xfer.reg_write, xfer.wb_from_mem,
                           xfer.dest_from_ctrl, xfer.addr2_from_ctrl},
                          {load, !load, load, load, load, !load}, "beat enables");
                    beat++;
                    @(negedge clk_i);
                    if (t.kind == K_ABORT && beat == ABORT_BEATS) begin
                        is_valid = 1'b0;
                        aborted = 1'b1;
                        done = 1'b1;
                    end
                    #1;
                end
            end
            if (aborted) begin
                check(xfer, '0, "transfer controls after abort");
                check(ctrl.valid, 1'b0, "valid after abort");
            end else begin
                check(beat, t.beats, "stall cycle count");
                check(xfer.reg_addr, {1'b0, t.instr[10:8]}, "write-back register");
                check(xfer.offset, t.wb_off, "write-back offset");
                check({xfer.stall, xfer.mem_read, xfer.mem_write, xfer.reg_write,
                       xfer.wb_from_mem, xfer.dest_from_ctrl, xfer.addr2_from_ctrl},
                      {3'b000, t.wb_write, 3'b010}, "write-back enables");
            end
        end
        report_test($sformatf("%0d %s %h", idx + 1, kind_name(t.kind), t.instr), errs_before);
    endtask

    initial begin : watchdog
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        int errs_before;
        reset_i = 1'b1;
        is_valid = 1'b0;
        instruction = '0;
        build_tests();
        watchdog_ns = (RESET_CYCLES + 4 + tests_q.size() * MAX_CYCLES_PER_TEST) * CLK_PERIOD;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;
        #1;
        errs_before = err_count;
        check({xfer.stall, xfer.mem_read, xfer.mem_write, xfer.reg_write}, '0,
              "transfer enables after reset");
        check({ctrl.valid, ctrl.mem_read, ctrl.mem_write, ctrl.reg_write}, '0,
              "control enables after reset");
        report_test("0 reset", errs_before);
        foreach (tests_q[i]) begin
            @(negedge clk_i);
            run_test(i);
        end
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_q.size() + 1, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* thumb_ctrl.f */
verilog/thumb_ctrl_pkg.sv
verilog/thumb_regs_pkg.sv
verilog/inst_decoder.sv
verilog/reg_list_picker.sv
verilog/transfer_counter.sv
verilog/multi_xfer_fsm.sv
verilog/thumb_ctrl.sv
verif/thumb_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := thumb_ctrl_tb
RTL_TOP   := thumb_ctrl
FILELIST  := thumb_ctrl.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Result: FAILED

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
